// ==== apb_cmd_arbiter.sv ====
`timescale 1ns/1ps

module apb_cmd_arbiter (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         i_rd_valid,
    input  apb_pkg::apb_cmd_t            i_rd_cmd,
    input  logic [axi_pkg::AXI_ID_W-1:0] i_rd_id,
    output logic                         o_rd_ready,
    input  logic                         i_wr_valid,
    input  apb_pkg::apb_cmd_t            i_wr_cmd,
    input  logic [axi_pkg::AXI_ID_W-1:0] i_wr_id,
    output logic                         o_wr_ready,
    output logic                         o_cmd_valid,
    output apb_pkg::apb_cmd_t            o_cmd,
    input  logic                         i_cmd_ready,
    output logic                         o_tag_valid,
    output apb_pkg::beat_tag_t           o_tag,
    input  logic                         i_tag_ready
);

    logic                         r_lock;
    logic                         r_lock_wr;
    logic                         r_prio_wr;
    logic [axi_pkg::AXI_ID_W-1:0] r_id;
    logic                         sel_wr;
    logic                         sel_valid;
    logic [axi_pkg::AXI_ID_W-1:0] sel_id;
    logic                         cmd_fire;

    // Locked owner wins, otherwise alternate on contention
    assign sel_wr    = r_lock ? r_lock_wr : (i_wr_valid && (!i_rd_valid || r_prio_wr));
    assign sel_valid = sel_wr ? i_wr_valid : i_rd_valid;
    assign sel_id    = sel_wr ? i_wr_id : i_rd_id;

    // Command and tag move together
    assign o_cmd_valid = sel_valid && i_tag_ready;
    assign o_tag_valid = sel_valid && i_cmd_ready;
    assign o_cmd       = sel_wr ? i_wr_cmd : i_rd_cmd;
    assign cmd_fire    = o_cmd_valid && i_cmd_ready;
    assign o_rd_ready  = !sel_wr && i_cmd_ready && i_tag_ready;
    assign o_wr_ready  = sel_wr && i_cmd_ready && i_tag_ready;

    always_comb begin
        o_tag          = '0;
        o_tag.is_write = sel_wr;
        o_tag.id       = r_lock ? r_id : sel_id;
        o_tag.last     = o_cmd.last;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_lock    <= 1'b0;
            r_lock_wr <= 1'b0;
            r_prio_wr <= 1'b0;
        end else if (cmd_fire && o_cmd.last) begin
            r_lock    <= 1'b0;
            r_prio_wr <= !sel_wr;
        end else if (!r_lock && sel_valid) begin
            r_lock    <= 1'b1;
            r_lock_wr <= sel_wr;
        end
    end

    always_ff @(posedge aclk) begin
        if (!r_lock) begin
            r_id <= sel_id;
        end
    end

endmodule

// ==== apb_pkg.sv ====
package apb_pkg;

    localparam int APB_ADDR_W = 32;
    localparam int APB_DATA_W = 32;
    localparam int APB_STRB_W = APB_DATA_W / 8;

    // One APB transfer, first and last mark the AXI burst ends
    typedef struct packed {
        logic                  pwrite;
        logic [2:0]            pprot;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
        logic [APB_STRB_W-1:0] pstrb;
        logic                  first;
        logic                  last;
    } apb_cmd_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pslverr;
    } apb_rsp_t;

    // Per-beat bookkeeping between command and response side
    typedef struct packed {
        logic                         is_write;
        logic [axi_pkg::AXI_ID_W-1:0] id;
        logic                         last;
    } beat_tag_t;

    // Align a byte address down to an APB word
    function automatic logic [APB_ADDR_W-1:0] word_addr(
        input logic [APB_ADDR_W-1:0] addr
    );
        logic [APB_ADDR_W-1:0] mask;
        mask = APB_ADDR_W'(APB_STRB_W - 1);
        return addr & ~mask;
    endfunction

endpackage

// ==== apb_rd_sequencer.sv ====
`timescale 1ns/1ps

module apb_rd_sequencer (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  axi_pkg::axi_addr_t           i_ar,
    input  logic                         i_arvalid,
    output logic                         o_arready,
    output logic                         o_req_valid,
    output apb_pkg::apb_cmd_t            o_req,
    output logic [axi_pkg::AXI_ID_W-1:0] o_req_id,
    input  logic                         i_req_ready
);

    logic                           r_busy;
    logic [axi_pkg::AXI_ADDR_W-1:0] r_addr;
    logic [axi_pkg::AXI_LEN_W-1:0]  r_len;
    logic [axi_pkg::AXI_LEN_W-1:0]  r_beat;
    logic [2:0]                     r_size;
    axi_pkg::burst_e                r_burst;
    logic [2:0]                     r_prot;
    logic [axi_pkg::AXI_ID_W-1:0]   r_id;
    logic                           ar_fire;
    logic                           req_fire;

    assign o_arready   = !r_busy;
    assign ar_fire     = i_arvalid && !r_busy;
    assign o_req_valid = r_busy;
    assign req_fire    = r_busy && i_req_ready;
    assign o_req_id    = r_id;

    always_comb begin
        o_req        = '0;
        o_req.pwrite = 1'b0;
        o_req.pprot  = r_prot;
        o_req.paddr  = apb_pkg::word_addr(r_addr);
        o_req.first  = (r_beat == '0);
        o_req.last   = (r_beat == r_len);
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_busy <= 1'b0;
        end else if (ar_fire) begin
            r_busy <= 1'b1;
        end else if (req_fire && (r_beat == r_len)) begin
            r_busy <= 1'b0;
        end
    end

    // Burst registers
    always_ff @(posedge aclk) begin
        if (ar_fire) begin
            r_addr  <= i_ar.addr;
            r_len   <= i_ar.len;
            r_beat  <= '0;
            r_size  <= i_ar.size;
            r_burst <= i_ar.burst;
            r_prot  <= i_ar.prot;
            r_id    <= i_ar.id;
        end else if (req_fire) begin
            r_addr <= axi_pkg::next_beat_addr(r_addr, r_size, r_burst);
            r_beat <= r_beat + 1'b1;
        end
    end

endmodule

// ==== apb_rsp_router.sv ====
`timescale 1ns/1ps

module apb_rsp_router (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               i_tag_valid,
    input  apb_pkg::beat_tag_t i_tag,
    output logic               o_tag_ready,
    input  apb_pkg::apb_rsp_t  i_rsp,
    input  logic               i_rsp_valid,
    output logic               o_rsp_ready,
    output axi_pkg::axi_r_t    o_r,
    output logic               o_rvalid,
    input  logic               i_rready,
    output axi_pkg::axi_b_t    o_b,
    output logic               o_bvalid,
    input  logic               i_bready
);

    logic r_wr_err;
    logic is_rd;
    logic is_wr_mid;
    logic is_wr_last;
    logic rsp_fire;

    assign is_rd      = i_tag_valid && !i_tag.is_write;
    assign is_wr_mid  = i_tag_valid && i_tag.is_write && !i_tag.last;
    assign is_wr_last = i_tag_valid && i_tag.is_write && i_tag.last;

    // Middle write beats only feed the error bit
    assign o_rsp_ready = (is_rd && i_rready) || is_wr_mid || (is_wr_last && i_bready);
    assign rsp_fire    = o_rsp_ready && i_rsp_valid;
    assign o_tag_ready = rsp_fire;

    assign o_rvalid = is_rd && i_rsp_valid;
    assign o_bvalid = is_wr_last && i_rsp_valid;

    always_comb begin
        o_r      = '0;
        o_r.id   = i_tag.id;
        o_r.data = i_rsp.prdata;
        o_r.resp = i_rsp.pslverr ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
        o_r.last = i_tag.last;
    end

    always_comb begin
        o_b      = '0;
        o_b.id   = i_tag.id;
        // Any failed beat of the burst fails the whole write
        o_b.resp = (r_wr_err || i_rsp.pslverr) ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_wr_err <= 1'b0;
        end else if (rsp_fire && is_wr_last) begin
            r_wr_err <= 1'b0;
        end else if (rsp_fire && is_wr_mid) begin
            r_wr_err <= r_wr_err || i_rsp.pslverr;
        end
    end

endmodule

// ==== apb_wr_sequencer.sv ====
`timescale 1ns/1ps

module apb_wr_sequencer (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  axi_pkg::axi_addr_t           i_aw,
    input  logic                         i_awvalid,
    output logic                         o_awready,
    input  axi_pkg::axi_w_t              i_w,
    input  logic                         i_wvalid,
    output logic                         o_wready,
    output logic                         o_req_valid,
    output apb_pkg::apb_cmd_t            o_req,
    output logic [axi_pkg::AXI_ID_W-1:0] o_req_id,
    input  logic                         i_req_ready
);

    logic                           r_busy;
    logic [axi_pkg::AXI_ADDR_W-1:0] r_addr;
    logic [axi_pkg::AXI_LEN_W-1:0]  r_len;
    logic [axi_pkg::AXI_LEN_W-1:0]  r_beat;
    logic [2:0]                     r_size;
    axi_pkg::burst_e                r_burst;
    logic [2:0]                     r_prot;
    logic [axi_pkg::AXI_ID_W-1:0]   r_id;
    logic                           aw_fire;
    logic                           req_fire;

    assign o_awready   = !r_busy;
    assign aw_fire     = i_awvalid && !r_busy;
    // A command needs the matching W beat
    assign o_req_valid = r_busy && i_wvalid;
    assign req_fire    = o_req_valid && i_req_ready;
    assign o_wready    = req_fire;
    assign o_req_id    = r_id;

    always_comb begin
        o_req        = '0;
        o_req.pwrite = 1'b1;
        o_req.pprot  = r_prot;
        o_req.paddr  = apb_pkg::word_addr(r_addr);
        o_req.pwdata = i_w.data;
        o_req.pstrb  = i_w.strb;
        o_req.first  = (r_beat == '0);
        o_req.last   = (r_beat == r_len);
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_busy <= 1'b0;
        end else if (aw_fire) begin
            r_busy <= 1'b1;
        end else if (req_fire && (r_beat == r_len)) begin
            r_busy <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_fire) begin
            r_addr  <= i_aw.addr;
            r_len   <= i_aw.len;
            r_beat  <= '0;
            r_size  <= i_aw.size;
            r_burst <= i_aw.burst;
            r_prot  <= i_aw.prot;
            r_id    <= i_aw.id;
        end else if (req_fire) begin
            r_addr <= axi_pkg::next_beat_addr(r_addr, r_size, r_burst);
            r_beat <= r_beat + 1'b1;
        end
    end

endmodule

// ==== axi2apb_top.sv ====
`timescale 1ns/1ps

module axi2apb_top #(
    parameter int TAG_DEPTH = 6
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  axi_pkg::axi_addr_t i_ar,
    input  logic               i_arvalid,
    output logic               o_arready,
    input  axi_pkg::axi_addr_t i_aw,
    input  logic               i_awvalid,
    output logic               o_awready,
    input  axi_pkg::axi_w_t    i_w,
    input  logic               i_wvalid,
    output logic               o_wready,
    output axi_pkg::axi_r_t    o_r,
    output logic               o_rvalid,
    input  logic               i_rready,
    output axi_pkg::axi_b_t    o_b,
    output logic               o_bvalid,
    input  logic               i_bready,
    output apb_pkg::apb_cmd_t  o_cmd,
    output logic               o_cmd_valid,
    input  logic               i_cmd_ready,
    input  apb_pkg::apb_rsp_t  i_rsp,
    input  logic               i_rsp_valid,
    output logic               o_rsp_ready
);

    logic                         rd_req_valid;
    apb_pkg::apb_cmd_t            rd_req;
    logic [axi_pkg::AXI_ID_W-1:0] rd_req_id;
    logic                         rd_req_ready;
    logic                         wr_req_valid;
    apb_pkg::apb_cmd_t            wr_req;
    logic [axi_pkg::AXI_ID_W-1:0] wr_req_id;
    logic                         wr_req_ready;
    logic                         tag_in_valid;
    apb_pkg::beat_tag_t           tag_in;
    logic                         tag_in_ready;
    logic                         tag_out_valid;
    apb_pkg::beat_tag_t           tag_out;
    logic                         tag_out_ready;

    apb_rd_sequencer u_rd_seq (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_ar        (i_ar),
        .i_arvalid   (i_arvalid),
        .o_arready   (o_arready),
        .o_req_valid (rd_req_valid),
        .o_req       (rd_req),
        .o_req_id    (rd_req_id),
        .i_req_ready (rd_req_ready)
    );

    apb_wr_sequencer u_wr_seq (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_aw        (i_aw),
        .i_awvalid   (i_awvalid),
        .o_awready   (o_awready),
        .i_w         (i_w),
        .i_wvalid    (i_wvalid),
        .o_wready    (o_wready),
        .o_req_valid (wr_req_valid),
        .o_req       (wr_req),
        .o_req_id    (wr_req_id),
        .i_req_ready (wr_req_ready)
    );

    apb_cmd_arbiter u_arb (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_rd_valid  (rd_req_valid),
        .i_rd_cmd    (rd_req),
        .i_rd_id     (rd_req_id),
        .o_rd_ready  (rd_req_ready),
        .i_wr_valid  (wr_req_valid),
        .i_wr_cmd    (wr_req),
        .i_wr_id     (wr_req_id),
        .o_wr_ready  (wr_req_ready),
        .o_cmd_valid (o_cmd_valid),
        .o_cmd       (o_cmd),
        .i_cmd_ready (i_cmd_ready),
        .o_tag_valid (tag_in_valid),
        .o_tag       (tag_in),
        .i_tag_ready (tag_in_ready)
    );

    beat_tag_fifo #(
        .DEPTH (TAG_DEPTH)
    ) u_tag_fifo (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_valid (tag_in_valid),
        .o_wr_ready (tag_in_ready),
        .i_wr_data  (tag_in),
        .o_rd_valid (tag_out_valid),
        .i_rd_ready (tag_out_ready),
        .o_rd_data  (tag_out)
    );

    apb_rsp_router u_rsp_router (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_tag_valid (tag_out_valid),
        .i_tag       (tag_out),
        .o_tag_ready (tag_out_ready),
        .i_rsp       (i_rsp),
        .i_rsp_valid (i_rsp_valid),
        .o_rsp_ready (o_rsp_ready),
        .o_r         (o_r),
        .o_rvalid    (o_rvalid),
        .i_rready    (i_rready),
        .o_b         (o_b),
        .o_bvalid    (o_bvalid),
        .i_bready    (i_bready)
    );

endmodule

// ==== axi_pkg.sv ====
package axi_pkg;

    localparam int AXI_ID_W   = 4;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;
    localparam int AXI_LEN_W  = 8;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // Shared by AR and AW
    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_LEN_W-1:0]  len;
        logic [2:0]            size;
        burst_e                burst;
        logic [2:0]            prot;
    } axi_addr_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        resp_e                 resp;
        logic                  last;
    } axi_r_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        resp_e               resp;
    } axi_b_t;

    // FIXED stays put, INCR steps by 2**size bytes
    function automatic logic [AXI_ADDR_W-1:0] next_beat_addr(
        input logic [AXI_ADDR_W-1:0] addr,
        input logic [2:0]            size,
        input burst_e                burst
    );
        logic [AXI_ADDR_W-1:0] step;
        step = AXI_ADDR_W'(1) << size;
        if (burst == BURST_FIXED) begin
            return addr;
        end
        return addr + step;
    endfunction

endpackage

// ==== beat_tag_fifo.sv ====
`timescale 1ns/1ps

module beat_tag_fifo #(
    parameter int DEPTH = 6
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               i_wr_valid,
    output logic               o_wr_ready,
    input  apb_pkg::beat_tag_t i_wr_data,
    output logic               o_rd_valid,
    input  logic               i_rd_ready,
    output apb_pkg::beat_tag_t o_rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    apb_pkg::beat_tag_t r_mem [DEPTH];
    logic [PTR_W-1:0]   r_wr_ptr;
    logic [PTR_W-1:0]   r_rd_ptr;
    logic [CNT_W-1:0]   r_count;
    logic               push;
    logic               pop;

    assign o_wr_ready = (r_count != CNT_W'(DEPTH));
    assign o_rd_valid = (r_count != '0);
    assign o_rd_data  = r_mem[r_rd_ptr];
    assign push       = i_wr_valid && o_wr_ready;
    assign pop        = i_rd_ready && o_rd_valid;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (push) begin
                r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
            end
            if (pop) begin
                r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                r_count <= r_count + 1'b1;
            end else if (pop && !push) begin
                r_count <= r_count - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            r_mem[r_wr_ptr] <= i_wr_data;
        end
    end

endmodule

// ==== flist.f ====
axi_pkg.sv
apb_pkg.sv
apb_rd_sequencer.sv
apb_wr_sequencer.sv
apb_cmd_arbiter.sv
beat_tag_fifo.sv
apb_rsp_router.sv
axi2apb_top.sv
tb_apb_target.sv
tb_axi2apb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AXI to APB bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_axi2apb_top -f flist.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1

// ==== tb_apb_target.sv ====
`timescale 1ns/1ps

module tb_apb_target (
    input  logic              aclk,
    input  logic              aresetn,
    input  apb_pkg::apb_cmd_t i_cmd,
    input  logic              i_cmd_valid,
    output logic              o_cmd_ready,
    output apb_pkg::apb_rsp_t o_rsp,
    output logic              o_rsp_valid,
    input  logic              i_rsp_ready
);

    localparam logic [31:0] ERR_BASE = 32'h0000_F000;

    logic [31:0]       mem [logic [31:0]];
    apb_pkg::apb_rsp_t rsp_q [$];
    logic              taken;

    initial begin
        o_cmd_ready = 1'b0;
        o_rsp       = '0;
        o_rsp_valid = 1'b0;
        taken       = 1'b0;
    end

    // Commands are served in order, responses queue up behind them
    always @(posedge aclk) begin : accept
        apb_pkg::apb_rsp_t rsp;
        logic [31:0]       word;
        if (aresetn && i_cmd_valid && o_cmd_ready) begin
            word = mem.exists(i_cmd.paddr) ? mem[i_cmd.paddr] : (i_cmd.paddr ^ 32'hC3A5_5A3C);
            rsp.pslverr = (i_cmd.paddr >= ERR_BASE);
            rsp.prdata  = i_cmd.pwrite ? 32'h0 : word;
            if (i_cmd.pwrite && !rsp.pslverr) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_cmd.pstrb[b]) begin
                        word[8*b +: 8] = i_cmd.pwdata[8*b +: 8];
                    end
                end
                mem[i_cmd.paddr] = word;
            end
            rsp_q.push_back(rsp);
        end
        if (o_rsp_valid && i_rsp_ready) begin
            void'(rsp_q.pop_front());
            taken = 1'b1;
        end
    end

    always @(negedge aclk) begin
        o_cmd_ready = ($urandom_range(3) != 0);
        if (taken) begin
            o_rsp_valid = 1'b0;
            taken       = 1'b0;
        end
        if (!o_rsp_valid && (rsp_q.size() > 0) && ($urandom_range(2) != 0)) begin
            o_rsp       = rsp_q[0];
            o_rsp_valid = 1'b1;
        end
    end

endmodule

// ==== tb_axi2apb_top.sv ====
`timescale 1ns/1ps

module tb_axi2apb_top;

    localparam int          NUM_TESTS       = 24;
    localparam int          MAX_BEATS       = 8;
    localparam logic [31:0] SEED            = 32'h2596_8c01;
    localparam logic [31:0] ERR_BASE        = 32'h0000_F000;
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * MAX_BEATS * 40;

    logic               aclk = 1'b0;
    logic               aresetn;
    axi_pkg::axi_addr_t i_ar;
    logic               i_arvalid;
    logic               o_arready;
    axi_pkg::axi_addr_t i_aw;
    logic               i_awvalid;
    logic               o_awready;
    axi_pkg::axi_w_t    i_w;
    logic               i_wvalid;
    logic               o_wready;
    axi_pkg::axi_r_t    o_r;
    logic               o_rvalid;
    logic               i_rready;
    axi_pkg::axi_b_t    o_b;
    logic               o_bvalid;
    logic               i_bready;
    apb_pkg::apb_cmd_t  o_cmd;
    logic               o_cmd_valid;
    logic               i_cmd_ready;
    apb_pkg::apb_rsp_t  i_rsp;
    logic               i_rsp_valid;
    logic               o_rsp_ready;

    int                 value_errors = 0;
    int                 other_errors = 0;
    logic [31:0]        ref_mem [logic [31:0]];
    apb_pkg::apb_cmd_t  rd_cmd_q [$];
    apb_pkg::apb_cmd_t  wr_cmd_q [$];
    axi_pkg::axi_r_t    r_q [$];
    axi_pkg::axi_b_t    b_q [$];
    axi_pkg::axi_addr_t bursts [NUM_TESTS];
    logic               burst_open = 1'b0;
    logic               burst_wr = 1'b0;

    always #10 aclk = ~aclk;

    axi2apb_top #(.TAG_DEPTH(6)) u_axi2apb_top (.*);

    tb_apb_target u_apb_target (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_cmd       (o_cmd),
        .i_cmd_valid (o_cmd_valid),
        .o_cmd_ready (i_cmd_ready),
        .o_rsp       (i_rsp),
        .o_rsp_valid (i_rsp_valid),
        .i_rsp_ready (o_rsp_ready)
    );

    function automatic logic [31:0] ref_word(input logic [31:0] wa);
        return ref_mem.exists(wa) ? ref_mem[wa] : (wa ^ 32'hC3A5_5A3C);
    endfunction

    function automatic logic [31:0] beat_word(input axi_pkg::axi_addr_t a, input int k);
        logic [31:0] byte_addr;
        byte_addr = a.addr;
        if (a.burst == axi_pkg::BURST_INCR) begin
            byte_addr = a.addr + (32'(k) << a.size);
        end
        return byte_addr & 32'hFFFF_FFFC;
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (exp === act) else begin
            value_errors++;
            $display("** Error at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // Every fourth burst starts just below the error window and crosses into it
    function automatic axi_pkg::axi_addr_t make_burst(input int idx);
        axi_pkg::axi_addr_t a;
        a.id    = 4'($urandom());
        a.len   = 8'($urandom_range(MAX_BEATS - 1));
        a.size  = 3'($urandom_range(2));
        a.burst = ($urandom_range(3) == 0) ? axi_pkg::BURST_FIXED : axi_pkg::BURST_INCR;
        a.prot  = 3'($urandom());
        if (idx % 4 == 3) begin
            a.addr  = ERR_BASE - 32'h10 + 32'($urandom_range(15));
            a.len   = 8'(4 + $urandom_range(MAX_BEATS - 5));
            a.size  = 3'd2;
            a.burst = axi_pkg::BURST_INCR;
        end else begin
            a.addr = 32'(idx) * 32'h80 + 32'($urandom_range(63));
        end
        return a;
    endfunction

    task automatic write_burst(input int idx);
        axi_pkg::axi_addr_t a;
        axi_pkg::axi_w_t    w;
        axi_pkg::axi_w_t    beats [$];
        apb_pkg::apb_cmd_t  c;
        axi_pkg::axi_b_t    b;
        logic [31:0]        wa;
        logic [31:0]        word;
        logic               err;
        a   = bursts[idx];
        err = 1'b0;
        for (int k = 0; k <= int'(a.len); k++) begin
            w.data = $urandom();
            w.strb = 4'($urandom());
            w.last = (k == int'(a.len));
            beats.push_back(w);
            wa       = beat_word(a, k);
            c        = '0;
            c.pwrite = 1'b1;
            c.pprot  = a.prot;
            c.paddr  = wa;
            c.pwdata = w.data;
            c.pstrb  = w.strb;
            c.first  = (k == 0);
            c.last   = w.last;
            wr_cmd_q.push_back(c);
            if (wa >= ERR_BASE) begin
                err = 1'b1;
            end else begin
                word = ref_word(wa);
                for (int n = 0; n < 4; n++) begin
                    if (w.strb[n]) begin
                        word[8*n +: 8] = w.data[8*n +: 8];
                    end
                end
                ref_mem[wa] = word;
            end
        end
        b.id   = a.id;
        b.resp = err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
        b_q.push_back(b);
        @(negedge aclk);
        i_aw      = a;
        i_awvalid = 1'b1;
        do @(posedge aclk); while (!o_awready);
        @(negedge aclk);
        i_awvalid = 1'b0;
        foreach (beats[k]) begin
            repeat ($urandom_range(1)) @(negedge aclk);
            i_w      = beats[k];
            i_wvalid = 1'b1;
            do @(posedge aclk); while (!o_wready);
            @(negedge aclk);
            i_wvalid = 1'b0;
        end
    endtask

    task automatic read_burst(input int idx);
        axi_pkg::axi_addr_t a;
        apb_pkg::apb_cmd_t  c;
        axi_pkg::axi_r_t    r;
        logic [31:0]        wa;
        a = bursts[idx];
        for (int k = 0; k <= int'(a.len); k++) begin
            wa      = beat_word(a, k);
            c       = '0;
            c.pprot = a.prot;
            c.paddr = wa;
            c.first = (k == 0);
            c.last  = (k == int'(a.len));
            rd_cmd_q.push_back(c);
            r.id   = a.id;
            r.data = ref_word(wa);
            r.resp = (wa >= ERR_BASE) ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
            r.last = c.last;
            r_q.push_back(r);
        end
        @(negedge aclk);
        i_ar      = a;
        i_arvalid = 1'b1;
        do @(posedge aclk); while (!o_arready);
        @(negedge aclk);
        i_arvalid = 1'b0;
    endtask

    task automatic check_cmd(input apb_pkg::apb_cmd_t c);
        apb_pkg::apb_cmd_t exp;
        assert (!burst_open || (c.pwrite == burst_wr)) else begin
            report_failure("commands of a read and a write burst interleave");
        end
        burst_open = !c.last;
        burst_wr   = c.pwrite;
        if (c.pwrite ? (wr_cmd_q.size() == 0) : (rd_cmd_q.size() == 0)) begin
            report_failure("APB command with no burst waiting for it");
        end else begin
            exp = c.pwrite ? wr_cmd_q.pop_front() : rd_cmd_q.pop_front();
            check_value("o_cmd.paddr", exp.paddr, c.paddr);
            check_value("o_cmd.pprot", exp.pprot, c.pprot);
            check_value("o_cmd.first", exp.first, c.first);
            check_value("o_cmd.last", exp.last, c.last);
            if (c.pwrite) begin
                check_value("o_cmd.pwdata", exp.pwdata, c.pwdata);
                check_value("o_cmd.pstrb", exp.pstrb, c.pstrb);
            end
        end
    endtask

    always @(negedge aclk) begin
        i_rready = ($urandom_range(3) != 0);
        i_bready = ($urandom_range(3) != 0);
    end

    always @(posedge aclk) begin : monitor
        axi_pkg::axi_r_t exp_r;
        axi_pkg::axi_b_t exp_b;
        logic            r_hold;
        logic            b_hold;
        axi_pkg::axi_r_t prev_r;
        axi_pkg::axi_b_t prev_b;
        if (!aresetn) begin
            r_hold = 1'b0;
            b_hold = 1'b0;
        end else begin
            if (r_hold) begin
                assert (o_rvalid) else report_failure("o_rvalid dropped while stalled");
                check_value("o_r (held)", prev_r, o_r);
            end
            if (b_hold) begin
                assert (o_bvalid) else report_failure("o_bvalid dropped while stalled");
                check_value("o_b (held)", prev_b, o_b);
            end
            r_hold = o_rvalid && !i_rready;
            b_hold = o_bvalid && !i_bready;
            prev_r = o_r;
            prev_b = o_b;
            if (o_rvalid && i_rready) begin
                if (r_q.size() == 0) begin
                    report_failure("R beat with no read beat outstanding");
                end else begin
                    exp_r = r_q.pop_front();
                    check_value("o_r.id", exp_r.id, o_r.id);
                    check_value("o_r.data", exp_r.data, o_r.data);
                    check_value("o_r.resp", exp_r.resp, o_r.resp);
                    check_value("o_r.last", exp_r.last, o_r.last);
                end
            end
            if (o_bvalid && i_bready) begin
                if (b_q.size() == 0) begin
                    report_failure("B response with no write burst outstanding");
                end else begin
                    exp_b = b_q.pop_front();
                    check_value("o_b.id", exp_b.id, o_b.id);
                    check_value("o_b.resp", exp_b.resp, o_b.resp);
                end
            end
            if (o_cmd_valid && i_cmd_ready) begin
                check_cmd(o_cmd);
            end
        end
    end

    task automatic wait_drained();
        while ((r_q.size() != 0) || (b_q.size() != 0)) begin
            @(posedge aclk);
        end
        @(negedge aclk);
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES + 16) @(posedge aclk);
        $display("Watchdog expired after %0d cycles with traffic still pending",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        void'($urandom(SEED));
        aresetn   = 1'b0;
        i_ar      = '0;
        i_arvalid = 1'b0;
        i_aw      = '0;
        i_awvalid = 1'b0;
        i_w       = '0;
        i_wvalid  = 1'b0;
        i_rready  = 1'b0;
        i_bready  = 1'b0;
        repeat (16) @(negedge aclk);
        check_value("o_cmd_valid", 1'b0, o_cmd_valid);
        check_value("o_rvalid", 1'b0, o_rvalid);
        check_value("o_bvalid", 1'b0, o_bvalid);
        check_value("o_wready", 1'b0, o_wready);
        check_value("o_rsp_ready", 1'b0, o_rsp_ready);
        check_value("o_arready", 1'b1, o_arready);
        check_value("o_awready", 1'b1, o_awready);
        aresetn = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            bursts[i] = make_burst(i);
        end
        // Write burst i runs against the read back of burst i-1
        for (int i = 0; i < NUM_TESTS; i++) begin
            fork
                write_burst(i);
                begin
                    if (i > 0) begin
                        read_burst(i - 1);
                    end
                end
            join
            wait_drained();
        end
        read_burst(NUM_TESTS - 1);
        wait_drained();
        repeat (4) @(negedge aclk);
        assert ((rd_cmd_q.size() == 0) && (wr_cmd_q.size() == 0)) else begin
            report_failure("APB commands predicted but never issued");
        end
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
